// File: all.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/line_store.sv
rtl/cache_way.sv
rtl/banked_mem.sv
rtl/miss_ctrl.sv
rtl/mem_system.sv
sim/tb_mem_system.sv

// File: run.sh
#!/bin/sh
# Compile the cache testbench with Verilator and run it.
# The run passes only when the testbench prints its pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_mem_system -o tb_mem_system -f all.f \
   && ./obj_dir/tb_mem_system | tee /dev/stderr | grep -qx '>>> PASS' \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: sim/tb_mem_system.sv
//////////////////////////////////////////////////////////////////////
// tb_mem_system: clock, reset and request driver for the cache
// Reference model of both ways, victim bit and sparse main memory
// Done-cycle assertions, request timeout and run watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "cache_params.svh"

module tb_mem_system
   import cache_pkg::*;
();

   localparam int PERIOD       = 100;
   localparam int RESET_CYCLES = 10;
   localparam int MAX_LAT      = 12;  // Longest request, dirty miss is 11
   localparam int N_RANDOM     = 400;
   localparam int N_REQ        = 15 + N_RANDOM;
   localparam int WATCHDOG_NS  = (N_REQ * MAX_LAT + RESET_CYCLES + 100) * PERIOD;
   localparam index_t IDX_POOL [4] = '{8'h00, 8'h01, 8'h80, 8'hff};

   logic        clk = 1'b0;
   logic        arst_n;
   logic [15:0] addr;
   word_t       data_in;
   logic        rd;
   logic        wr;
   word_t       data_out;
   logic        done;
   logic        stall;
   logic        cache_hit;
   logic        err;

   // Reference state, two ways per set
   tag_t  m_tag   [2][256];
   logic  m_valid [2][256];
   logic  m_dirty [2][256];
   word_t m_data  [2][256][4];
   logic  m_victim;
   word_t m_mem   [logic [15:0]]; // Only words written back

   mem_system dut (
      .clk (clk), .arst_n (arst_n), .addr (addr), .data_in (data_in), .rd (rd), .wr (wr),
      .data_out (data_out), .done (done), .stall (stall), .cache_hit (cache_hit), .err (err)
   );

   always #(PERIOD / 2) clk = ~clk;

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic expect_bit(input string name, input logic exp_v, input logic act);
      assert (act === exp_v) else
         stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected %b, got %b",
                                     $time, name, exp_v, act));
   endtask

   task automatic expect_word(input string name, input word_t exp_v, input word_t act);
      assert (act === exp_v) else
         stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected 'h%h, got 'h%h",
                                     $time, name, exp_v, act));
   endtask

   function automatic logic [15:0] make_addr(input tag_t t, input index_t i, input offset_t o);
      return {t, i, o, 1'b0};
   endfunction

   function automatic word_t mem_value(input logic [15:0] a);
      if (m_mem.exists(a)) return m_mem[a];
      return a ^ `CACHE_MEM_INIT_XOR; // Untouched words keep the init pattern
   endfunction

   task automatic model_reset();
      for (int w = 0; w < 2; w++) begin
         for (int i = 0; i < 256; i++) begin
            m_tag[w][i]   = '0;
            m_valid[w][i] = 1'b0;
            m_dirty[w][i] = 1'b0;
         end
      end
      m_victim = 1'b1;
   endtask

   // Applies one request to the model and returns what done must show
   task automatic model_access(input logic [15:0] a, input word_t d, input logic r,
                               input logic w, output word_t exp_data, output logic exp_hit,
                               output logic exp_err, output int exp_lat);
      tag_t    t;
      index_t  i;
      offset_t o;
      int      way;
      t        = a[15:11];
      i        = a[10:3];
      o        = a[2:1];
      way      = -1;
      exp_data = '0;
      exp_hit  = 1'b0;
      exp_err  = 1'b0;
      exp_lat  = 1;
      if (a[0] || (r && w)) begin
         exp_err = 1'b1; // Cache and memory untouched
      end else begin
         for (int k = 0; k < 2; k++) begin
            if (m_valid[k][i] && m_tag[k][i] == t) way = k;
         end
         if (way >= 0) begin
            exp_hit = 1'b1;
         end else begin
            // Invalid way first, way 0 when both are free
            if (m_valid[0][i] && m_valid[1][i]) way = int'(m_victim);
            else way = (m_valid[0][i] && !m_valid[1][i]) ? 1 : 0;
            exp_lat = 7;
            if (m_valid[way][i] && m_dirty[way][i]) begin
               exp_lat = 11;
               for (int k = 0; k < 4; k++) begin
                  m_mem[make_addr(m_tag[way][i], i, offset_t'(k))] = m_data[way][i][k];
               end
            end
            for (int k = 0; k < 4; k++) begin
               m_data[way][i][k] = mem_value(make_addr(t, i, offset_t'(k)));
            end
            m_tag[way][i]   = t;
            m_valid[way][i] = 1'b1;
            m_dirty[way][i] = 1'b0;
         end
         if (w) begin
            m_data[way][i][o] = d;
            m_dirty[way][i]   = 1'b1;
         end
         exp_data = m_data[way][i][o];
      end
      m_victim = ~m_victim; // Every done flips it
   endtask

   // Drives one request, holds it until done and checks the done cycle
   task automatic do_req(input logic [15:0] a, input word_t d, input logic r, input logic w);
      word_t exp_data;
      logic  exp_hit;
      logic  exp_err;
      int    exp_lat;
      int    cycles;
      model_access(a, d, r, w, exp_data, exp_hit, exp_err, exp_lat);
      @(posedge clk);
      #1;
      addr    = a;
      data_in = d;
      rd      = r;
      wr      = w;
      @(negedge clk);
      expect_bit("done", 1'b0, done);   // Previous pulse is over
      expect_bit("stall", 1'b0, stall);
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         expect_bit("stall", 1'b1, stall);
         if (!done && cycles >= MAX_LAT)
            stop_with_failure($sformatf("No done within %0d cycles of the request to 'h%h",
                                        MAX_LAT, a));
      end while (!done);
      expect_word("done latency", 16'(exp_lat), 16'(cycles));
      expect_bit("err", exp_err, err);
      expect_bit("cache_hit", exp_hit, cache_hit);
      if (r && !exp_err) expect_word("data_out", exp_data, data_out);
   endtask

   initial begin
      #(WATCHDOG_NS);
      stop_with_failure("Watchdog expired, the DUT stopped finishing requests");
   end

   initial begin
      tag_t    t;
      index_t  i;
      offset_t o;
      logic    is_wr;
      void'($urandom(32'hdd88_0dec));
      arst_n  = 1'b0;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      model_reset();
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      arst_n = 1'b1;
      @(negedge clk);
      expect_bit("done", 1'b0, done);
      expect_bit("stall", 1'b0, stall);
      expect_bit("err", 1'b0, err);
      expect_bit("cache_hit", 1'b0, cache_hit);
      do_req(16'h1234, '0, 1'b1, 1'b0);      // Cold read
      do_req(16'h2468, 16'hbeef, 1'b0, 1'b1);
      do_req(16'h2468, '0, 1'b1, 1'b0);      // Hit, one cycle
      do_req(16'h1234, 16'h5a5a, 1'b0, 1'b1); // Write hit
      do_req(16'h1234, '0, 1'b1, 1'b0);
      // Three tags on one set, third write evicts a dirty line
      do_req(make_addr(5'h03, 8'h40, 2'd1), 16'h1111, 1'b0, 1'b1);
      do_req(make_addr(5'h0a, 8'h40, 2'd2), 16'h2222, 1'b0, 1'b1);
      do_req(make_addr(5'h11, 8'h40, 2'd3), 16'h3333, 1'b0, 1'b1);
      do_req(make_addr(5'h03, 8'h40, 2'd1), '0, 1'b1, 1'b0);
      do_req(make_addr(5'h0a, 8'h40, 2'd2), '0, 1'b1, 1'b0);
      do_req(make_addr(5'h11, 8'h40, 2'd3), '0, 1'b1, 1'b0);
      // Bad requests
      do_req(16'h2469, '0, 1'b1, 1'b0);
      do_req(16'h2469, 16'hdead, 1'b0, 1'b1);
      do_req(16'h2468, 16'h0bad, 1'b1, 1'b1);
      do_req(16'h2468, '0, 1'b1, 1'b0);
      for (int n = 0; n < N_RANDOM; n++) begin
         t     = tag_t'($urandom_range(3, 0));
         i     = IDX_POOL[$urandom_range(3, 0)];
         o     = offset_t'($urandom_range(3, 0));
         is_wr = 1'($urandom_range(1, 0));
         do_req(make_addr(t, i, o), word_t'($urandom), !is_wr, is_wr);
      end
      @(posedge clk);
      #1;
      rd = 1'b0;
      wr = 1'b0;
      @(negedge clk);
      expect_bit("done", 1'b0, done);
      expect_bit("stall", 1'b0, stall);
      $display(">>> PASS");
      $finish;
   end

endmodule

// File: rtl/mem_system.sv
//////////////////////////////////////////////////////////////////////
// mem_system: two-way write-back cache over four-bank memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "cache_params.svh"

module mem_system
   import cache_pkg::*;
(
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [`CACHE_ADDR_W-1:0] addr,
   input  word_t                    data_in,
   input  logic                     rd,
   input  logic                     wr,
   output word_t                    data_out,
   output logic                     done,
   output logic                     stall,
   output logic                     cache_hit,
   output logic                     err
);

   tag_t    req_tag;
   index_t  req_index;
   logic    en_0, en_1, comp, write, valid_in;
   offset_t offset;
   word_t   way_wdata, way_data_0, way_data_1;
   tag_t    tag_out_0, tag_out_1;
   logic    hit_0, hit_1, valid_0, valid_1, dirty_0, dirty_1;
   logic [`CACHE_ADDR_W-1:0] mem_addr;
   word_t   mem_wdata, mem_rdata;
   logic    mem_rd, mem_wr;

   assign req_tag   = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
   assign req_index = addr[`CACHE_OFFSET_W+1 +: `CACHE_INDEX_W];

   // Write reaches a way only with its own enable
   cache_way way_0 (
      .clk (clk), .arst_n (arst_n), .enable (en_0), .index (req_index),
      .offset (offset), .tag_in (req_tag), .comp (comp), .write (write & en_0),
      .valid_in (valid_in), .data_in (way_wdata), .data_out (way_data_0),
      .tag_out (tag_out_0), .hit (hit_0), .valid (valid_0), .dirty (dirty_0)
   );

   cache_way way_1 (
      .clk (clk), .arst_n (arst_n), .enable (en_1), .index (req_index),
      .offset (offset), .tag_in (req_tag), .comp (comp), .write (write & en_1),
      .valid_in (valid_in), .data_in (way_wdata), .data_out (way_data_1),
      .tag_out (tag_out_1), .hit (hit_1), .valid (valid_1), .dirty (dirty_1)
   );

   miss_ctrl ctrl (.*);

   banked_mem mem (.*);

endmodule

// File: rtl/miss_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Cache controller FSM
// Way lookup merge and victim choice
// Writeback and fill sequencing
// Requester done, stall and err generation
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "cache_params.svh"

module miss_ctrl
   import cache_pkg::*;
(
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [`CACHE_ADDR_W-1:0] addr,
   input  word_t                    data_in,
   input  logic                     rd,
   input  logic                     wr,
   input  logic                     hit_0,
   input  logic                     hit_1,
   input  logic                     valid_0,
   input  logic                     valid_1,
   input  logic                     dirty_0,
   input  logic                     dirty_1,
   input  word_t                    way_data_0,
   input  word_t                    way_data_1,
   input  tag_t                     tag_out_0,
   input  tag_t                     tag_out_1,
   output logic                     en_0,
   output logic                     en_1,
   output offset_t                  offset,
   output logic                     comp,
   output logic                     write,
   output logic                     valid_in,
   output word_t                    way_wdata,
   output logic [`CACHE_ADDR_W-1:0] mem_addr,
   output word_t                    mem_wdata,
   output logic                     mem_rd,
   output logic                     mem_wr,
   input  word_t                    mem_rdata,
   output word_t                    data_out,
   output logic                     done,
   output logic                     stall,
   output logic                     cache_hit,
   output logic                     err
);

   localparam int WORDS     = `CACHE_WORDS_PER_LINE;
   localparam int LAT       = `CACHE_MEM_RD_LAT;
   localparam int WB_LAST   = WORDS - 1;
   localparam int FILL_LAST = WORDS + LAT - 1; // Last read issue plus latency

   ctrl_state_t state, next_state;
   tag_t        req_tag;
   index_t      req_index;
   offset_t     req_offset;
   logic        bad_req;
   logic        way_pick;  // Way for this request's refill
   logic        pick_dirty;
   logic        way_sel;   // Registered way_pick
   logic        wr_q;
   logic        victim;
   logic [2:0]  cnt;       // Word counter in WRITEBACK and FILL
   word_t       hit_data;
   word_t       sel_data;
   tag_t        sel_tag;

   assign {req_tag, req_index, req_offset} = addr[`CACHE_ADDR_W-1:1];
   assign bad_req = addr[0] | (rd & wr);

   // Invalid way first, then the global victim bit
   assign way_pick   = (valid_0 & valid_1) ? victim : (valid_0 & ~valid_1);
   assign pick_dirty = way_pick ? (valid_1 & dirty_1) : (valid_0 & dirty_0);

   assign sel_data = way_sel ? way_data_1 : way_data_0;
   assign sel_tag  = way_sel ? tag_out_1 : tag_out_0;

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (rd || wr) begin
               if (bad_req)           next_state = REJECT;
               else if (hit_0 || hit_1) next_state = HIT;
               else if (pick_dirty)   next_state = WRITEBACK;
               else                   next_state = FILL;
            end
         end
         WRITEBACK: if (cnt == 3'(WB_LAST)) next_state = FILL;
         FILL:      if (cnt == 3'(FILL_LAST)) next_state = FINISH;
         default:   next_state = IDLE; // HIT, FINISH, REJECT last one cycle
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= IDLE;
         cnt     <= '0;
         victim  <= 1'b1;
         way_sel <= 1'b0;
         wr_q    <= 1'b0;
      end else begin
         state <= next_state;
         if (next_state != state) begin
            cnt <= '0;
         end else if (state == WRITEBACK || state == FILL) begin
            cnt <= cnt + 3'd1;
         end
         if (done) victim <= ~victim;
         if (state == IDLE) begin // Capture at the request edge
            way_sel <= way_pick;
            wr_q    <= wr;
         end
      end
   end

   // Read data or written word for the hit done
   always_ff @(posedge clk) begin
      if (state == IDLE) begin
         hit_data <= wr ? data_in : (hit_1 ? way_data_1 : way_data_0);
      end
   end

   assign stall = (state != IDLE);

   always_comb begin
      en_0      = 1'b0;
      en_1      = 1'b0;
      offset    = req_offset;
      comp      = 1'b0;
      write     = 1'b0;
      valid_in  = 1'b0;
      way_wdata = data_in;
      mem_addr  = '0;
      mem_wdata = sel_data;
      mem_rd    = 1'b0;
      mem_wr    = 1'b0;
      data_out  = '0;
      done      = 1'b0;
      cache_hit = 1'b0;
      err       = 1'b0;
      case (state)
         IDLE: begin // Lookup in both ways
            en_0  = (rd | wr) & ~bad_req;
            en_1  = (rd | wr) & ~bad_req;
            comp  = 1'b1;
            write = wr;
         end
         HIT: begin
            done      = 1'b1;
            cache_hit = 1'b1;
            data_out  = hit_data;
         end
         WRITEBACK: begin
            {en_1, en_0} = way_sel ? 2'b10 : 2'b01;
            offset       = offset_t'(cnt);
            mem_wr       = 1'b1;
            mem_addr     = {sel_tag, req_index, offset_t'(cnt), 1'b0};
         end
         FILL: begin
            if (cnt < 3'(WORDS)) begin // Issue reads
               mem_rd   = 1'b1;
               mem_addr = {req_tag, req_index, offset_t'(cnt), 1'b0};
            end
            if (cnt >= 3'(LAT)) begin // Returned words trail the reads by LAT
               {en_1, en_0} = way_sel ? 2'b10 : 2'b01;
               offset       = offset_t'(cnt - 3'(LAT));
               write        = 1'b1;
               valid_in     = 1'b1;
               way_wdata    = mem_rdata;
            end
         end
         FINISH: begin
            {en_1, en_0} = way_sel ? 2'b10 : 2'b01;
            comp         = 1'b1;
            write        = wr_q;
            done         = 1'b1;
            data_out     = sel_data;
         end
         REJECT: begin
            done = 1'b1;
            err  = 1'b1;
         end
         default: ;
      endcase
   end

   a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      done |=> !done);
   a_one_hit: assert property (@(posedge clk) disable iff (!arst_n)
      !(hit_0 && hit_1));
   // Busy states never fall back to IDLE without done
   a_busy_stall: assert property (@(posedge clk) disable iff (!arst_n)
      (stall && !done) |=> stall);

endmodule

// File: rtl/banked_mem.sv
//////////////////////////////////////////////////////////////////////
// banked_mem: four-bank main memory interleaved on word offset
// Pipelined reads with fixed latency, single-cycle writes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "cache_params.svh"

module banked_mem
   import cache_pkg::*;
(
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [`CACHE_ADDR_W-1:0] mem_addr,
   input  word_t                    mem_wdata,
   input  logic                     mem_rd,
   input  logic                     mem_wr,
   output word_t                    mem_rdata
);

   localparam int BANKS = `CACHE_WORDS_PER_LINE;
   localparam int ROW_W = `CACHE_ADDR_W - `CACHE_OFFSET_W - 1;
   localparam int ROWS  = 1 << ROW_W;
   localparam int LAT   = `CACHE_MEM_RD_LAT;

   word_t            bank [BANKS][ROWS];
   offset_t          bank_sel;
   logic [ROW_W-1:0] row;
   word_t            rd_pipe [LAT]; // Read data stages
   logic [LAT-1:0]   rd_vld;

   assign bank_sel = mem_addr[`CACHE_OFFSET_W:1];
   assign row      = mem_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W+1];

   // Simulation-only contents, word at byte address a holds a ^ pattern
   initial begin
      for (int r = 0; r < ROWS; r++) begin
         for (int b = 0; b < BANKS; b++) begin
            bank[b][r] = word_t'((r << (`CACHE_OFFSET_W + 1)) | (b << 1)) ^
                         `CACHE_MEM_INIT_XOR;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (mem_wr) begin
         bank[bank_sel][row] <= mem_wdata;
      end
      rd_pipe[0] <= bank[bank_sel][row];
      for (int i = 1; i < LAT; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   // Valid bits follow the data down the pipe
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_vld <= '0;
      end else begin
         rd_vld <= {rd_vld[LAT-2:0], mem_rd};
      end
   end

   assign mem_rdata = rd_vld[LAT-1] ? rd_pipe[LAT-1] : '0;

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
      !(mem_rd && mem_wr));

endmodule

// File: rtl/cache_way.sv
//////////////////////////////////////////////////////////////////////
// cache_way: one way of the cache, tag store plus data store
// Hit/valid/dirty lookup and the compare and fill write rules
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "cache_params.svh"

module cache_way
   import cache_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n,
   input  logic    enable,
   input  index_t  index,
   input  offset_t offset,
   input  tag_t    tag_in,
   input  logic    comp,
   input  logic    write,
   input  logic    valid_in,
   input  word_t   data_in,
   output word_t   data_out,
   output tag_t    tag_out,
   output logic    hit,
   output logic    valid,
   output logic    dirty
);

   tag_entry_t entry;     // Entry at the current index
   tag_entry_t entry_new;
   logic       tag_we;
   logic       data_we;

   line_store #(
      .entry_t   (tag_entry_t),
      .ADDR_BITS (`CACHE_INDEX_W)
   ) tag_store (
      .clk    (clk),
      .arst_n (arst_n),
      .raddr  (index),
      .rdata  (entry),
      .we     (tag_we),
      .waddr  (index),
      .wdata  (entry_new)
   );

   // One word per index and offset
   line_store #(
      .entry_t   (word_t),
      .ADDR_BITS (`CACHE_INDEX_W + `CACHE_OFFSET_W)
   ) data_store (
      .clk    (clk),
      .arst_n (arst_n),
      .raddr  ({index, offset}),
      .rdata  (data_out),
      .we     (data_we),
      .waddr  ({index, offset}),
      .wdata  (data_in)
   );

   assign tag_out = entry.tag;
   assign valid   = entry.valid;
   assign dirty   = entry.dirty;
   assign hit     = enable & entry.valid & (entry.tag == tag_in);

   always_comb begin
      tag_we    = 1'b0;
      data_we   = 1'b0;
      entry_new = entry;
      if (enable && write) begin
         if (comp) begin
            if (hit) begin // Write hit marks the line dirty
               tag_we          = 1'b1;
               data_we         = 1'b1;
               entry_new.dirty = 1'b1;
            end
         end else begin // Fill word, tag loaded, clean
            tag_we    = 1'b1;
            data_we   = 1'b1;
            entry_new = '{valid: valid_in, dirty: 1'b0, tag: tag_in};
         end
      end
   end

   a_write_enabled: assert property (@(posedge clk) disable iff (!arst_n)
      write |-> enable);

endmodule

// File: rtl/line_store.sv
//////////////////////////////////////////////////////////////////////
// line_store: flop array with asynchronous read, clocked write
// Payload type set by parameter, cleared on reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module line_store #(
   parameter type entry_t = logic,
   parameter int  ADDR_BITS = 8
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic [ADDR_BITS-1:0] raddr,
   output entry_t               rdata,
   input  logic                 we,
   input  logic [ADDR_BITS-1:0] waddr,
   input  entry_t               wdata
);

   localparam int DEPTH = 1 << ADDR_BITS;

   entry_t mem [DEPTH];

   assign rdata = mem[raddr]; // Combinational read

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (we) begin
         mem[waddr] <= wdata;
      end
   end

   a_waddr_known: assert property (@(posedge clk) disable iff (!arst_n)
      we |-> !$isunknown(waddr));

endmodule

// File: rtl/cache_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared cache types: data word, address fields, tag store entry
// and miss controller state encoding
//////////////////////////////////////////////////////////////////////

`include "cache_params.svh"

package cache_pkg;

   typedef logic [`CACHE_WORD_W-1:0]   word_t;

   // Address fields
   typedef logic [`CACHE_TAG_W-1:0]    tag_t;
   typedef logic [`CACHE_INDEX_W-1:0]  index_t;
   typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

   // One tag store entry per set and way
   typedef struct packed {
      logic valid;
      logic dirty;
      tag_t tag;
   } tag_entry_t;

   typedef enum logic [2:0] {
      IDLE,      // Waiting for rd or wr, lookup runs here
      HIT,       // Done after a hit
      WRITEBACK, // Dirty victim to memory
      FILL,      // Line from memory into the way
      FINISH,    // Original access on the filled line
      REJECT     // Bad request, done with err
   } ctrl_state_t;

endpackage

// File: rtl/cache_params.svh
//////////////////////////////////////////////////////////////////////
// Cache geometry macros: address, word and field widths
// Words per line, main memory read latency, memory init pattern
//////////////////////////////////////////////////////////////////////

`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Byte address and data word
`define CACHE_ADDR_W   16
`define CACHE_WORD_W   16

// Address split: tag | index | word offset | byte bit
`define CACHE_TAG_W    5
`define CACHE_INDEX_W  8
`define CACHE_OFFSET_W 2

`define CACHE_WORDS_PER_LINE 4

// Main memory
`define CACHE_MEM_RD_LAT   2        // Cycles from read issue to data
`define CACHE_MEM_INIT_XOR 16'ha5c3 // Word at byte address a starts as a ^ this

`endif
